//--- rtl/vga_pkg.sv
// Shared types for the game video path
// Width typedefs, color constants, winner stripe table and the raster structs

package vga_pkg;

  typedef logic [10:0] coord_t;       // Pixel or line counter
  typedef logic [11:0] rgb_t;         // 4 bits each of red, green, blue
  typedef logic [4:0]  stripe_idx_t;  // Stripe number on the winner screen

  localparam rgb_t WHITE  = 12'hfff;
  localparam rgb_t BLACK  = 12'h000;
  localparam rgb_t RED    = 12'hf00;
  localparam rgb_t GREEN  = 12'h0f0;
  localparam rgb_t BLUE   = 12'h00f;
  localparam rgb_t YELLOW = 12'hff0;

  localparam int NUM_STRIPES = 25;

  // Stripe colors from left to right, the last entry also covers the columns beyond it
  localparam rgb_t stripe_color [0:NUM_STRIPES-1] = '{
    YELLOW,  // 0
    RED,
    BLACK,
    GREEN,
    YELLOW,
    RED,     // 5
    BLUE,
    YELLOW,
    RED,
    YELLOW,
    BLACK,   // 10
    YELLOW,
    GREEN,
    RED,
    YELLOW,
    BLUE,    // 15
    BLACK,
    YELLOW,
    GREEN,
    RED,
    BLUE,    // 20
    YELLOW,
    YELLOW,
    GREEN,
    RED
  };

  // Raster position and timing flags of one pixel
  typedef struct packed {
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
  } vga_sig_t;

  // Raster signals together with the color drawn for that pixel
  typedef struct packed {
    vga_sig_t sig;
    rgb_t     rgb;
  } vga_px_t;

endpackage

//--- rtl/vga_timing.sv
// Raster timing generator
// Free-running pixel and line counters with registered sync and blanking

`timescale 1ns/1ps

module vga_timing #(
  parameter int H_ACTIVE = 800,
  parameter int H_FP     = 40,
  parameter int H_SYNC   = 128,
  parameter int H_BP     = 88,
  parameter int V_ACTIVE = 600,
  parameter int V_FP     = 1,
  parameter int V_SYNC   = 4,
  parameter int V_BP     = 23
) (
  input  logic              clk,
  input  logic              rst,
  output vga_pkg::vga_sig_t tim
);

  import vga_pkg::*;

  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

  localparam coord_t H_LAST     = coord_t'(H_TOTAL - 1);
  localparam coord_t V_LAST     = coord_t'(V_TOTAL - 1);
  localparam coord_t H_BLANK_ON = coord_t'(H_ACTIVE);
  localparam coord_t V_BLANK_ON = coord_t'(V_ACTIVE);
  localparam coord_t H_SYNC_ON  = coord_t'(H_ACTIVE + H_FP);
  localparam coord_t H_SYNC_OFF = coord_t'(H_ACTIVE + H_FP + H_SYNC);
  localparam coord_t V_SYNC_ON  = coord_t'(V_ACTIVE + V_FP);
  localparam coord_t V_SYNC_OFF = coord_t'(V_ACTIVE + V_FP + V_SYNC);

  logic     h_wrap;
  vga_sig_t tim_nxt;

  assign h_wrap = (tim.hcount == H_LAST);

  // Flags are derived from the next counter values so that
  // they line up with the counters once registered
  always_comb begin
    tim_nxt = tim;

    if (h_wrap) begin
      tim_nxt.hcount = '0;
      if (tim.vcount == V_LAST) begin
        tim_nxt.vcount = '0;
      end else begin
        tim_nxt.vcount = tim.vcount + 1'b1;
      end
    end else begin
      tim_nxt.hcount = tim.hcount + 1'b1;
    end

    tim_nxt.hblnk = (tim_nxt.hcount >= H_BLANK_ON);
    tim_nxt.vblnk = (tim_nxt.vcount >= V_BLANK_ON);
    tim_nxt.hsync = (tim_nxt.hcount >= H_SYNC_ON) && (tim_nxt.hcount < H_SYNC_OFF);
    tim_nxt.vsync = (tim_nxt.vcount >= V_SYNC_ON) && (tim_nxt.vcount < V_SYNC_OFF);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tim <= '0;
    end else begin
      tim <= tim_nxt;
    end
  end

  // Counters stay inside the raster
  assert property (@(posedge clk) disable iff (rst)
    (tim.hcount < coord_t'(H_TOTAL)) && (tim.vcount < coord_t'(V_TOTAL)))
    else $error("raster counter outside the frame");

endmodule

//--- rtl/draw_screen_winner.sv
// Winner screen renderer
// Vertical colored stripes inside a white border with a white center panel

`timescale 1ns/1ps

module draw_screen_winner #(
  parameter int H_ACTIVE = 800,
  parameter int V_ACTIVE = 600,
  parameter int STRIPE_W = 32,
  parameter int OUTER_W  = 40,
  parameter int OUTER_H  = 40,
  parameter int INNER_W  = 200,
  parameter int INNER_H  = 150
) (
  input  logic              clk,
  input  logic              rst,
  input  vga_pkg::vga_sig_t tim,
  output vga_pkg::vga_px_t  px
);

  import vga_pkg::*;

  // Outer rectangle, right edge inclusive and bottom edge exclusive
  localparam coord_t OUT_X0 = coord_t'(OUTER_W);
  localparam coord_t OUT_X1 = coord_t'(H_ACTIVE - OUTER_W);
  localparam coord_t OUT_Y0 = coord_t'(OUTER_H);
  localparam coord_t OUT_Y1 = coord_t'(V_ACTIVE - OUTER_H);

  // Inner panel, all edges inclusive
  localparam coord_t IN_X0 = coord_t'(INNER_W);
  localparam coord_t IN_X1 = coord_t'(H_ACTIVE - INNER_W);
  localparam coord_t IN_Y0 = coord_t'(INNER_H);
  localparam coord_t IN_Y1 = coord_t'(V_ACTIVE - INNER_H);

  localparam stripe_idx_t LAST_STRIPE = stripe_idx_t'(NUM_STRIPES - 1);

  coord_t      stripe_raw;
  stripe_idx_t stripe_idx;
  logic        outside_outer;
  logic        in_inner;
  rgb_t        rgb_nxt;

  always_comb begin
    stripe_raw = tim.hcount / coord_t'(STRIPE_W);
    if (stripe_raw > coord_t'(LAST_STRIPE)) begin
      stripe_idx = LAST_STRIPE;  // Everything past the last stripe keeps its color
    end else begin
      stripe_idx = stripe_idx_t'(stripe_raw);
    end
  end

  assign outside_outer = !((tim.hcount >= OUT_X0) && (tim.hcount <= OUT_X1) &&
                           (tim.vcount >= OUT_Y0) && (tim.vcount < OUT_Y1));

  assign in_inner = (tim.hcount >= IN_X0) && (tim.hcount <= IN_X1) &&
                    (tim.vcount >= IN_Y0) && (tim.vcount <= IN_Y1);

  always_comb begin
    rgb_nxt = stripe_color[stripe_idx];
    if (outside_outer || in_inner) begin
      rgb_nxt = WHITE;  // Border and panel cover the stripes
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      px <= '0;
    end else begin
      px.sig <= tim;
      px.rgb <= rgb_nxt;
    end
  end

  // The table lookup never runs past its last entry
  assert property (@(posedge clk) disable iff (rst)
    stripe_idx <= LAST_STRIPE)
    else $error("stripe index beyond the color table");

endmodule

//--- rtl/draw_screen_idle.sv
// Idle screen renderer
// Two-color checkerboard drawn from the raster position

`timescale 1ns/1ps

module draw_screen_idle #(
  parameter int CHECK_SHIFT = 5
) (
  input  logic              clk,
  input  logic              rst,
  input  vga_pkg::vga_sig_t tim,
  output vga_pkg::vga_px_t  px
);

  import vga_pkg::*;

  logic odd_square;
  rgb_t rgb_nxt;

  // Squares are 2**CHECK_SHIFT pixels on a side
  assign odd_square = tim.hcount[CHECK_SHIFT] ^ tim.vcount[CHECK_SHIFT];

  always_comb begin
    if (odd_square) begin
      rgb_nxt = BLUE;
    end else begin
      rgb_nxt = BLACK;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      px <= '0;
    end else begin
      px.sig <= tim;
      px.rgb <= rgb_nxt;
    end
  end

endmodule

//--- rtl/screen_select.sv
// Screen selector
// Latches the screen choice once per frame, picks that pixel and blanks it

`timescale 1ns/1ps

module screen_select #(
  parameter int V_ACTIVE = 600
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             winner,
  input  vga_pkg::vga_px_t win_px,
  input  vga_pkg::vga_px_t idle_px,
  output vga_pkg::vga_px_t px
);

  import vga_pkg::*;

  localparam coord_t FIRST_BLANK_LINE = coord_t'(V_ACTIVE);

  logic    frame_edge;
  logic    show_winner;
  vga_px_t sel_px;

  // First pixel of the first blank line, nothing visible changes here
  assign frame_edge = (win_px.sig.hcount == '0) && (win_px.sig.vcount == FIRST_BLANK_LINE);

  always_ff @(posedge clk) begin
    if (rst) begin
      show_winner <= 1'b0;
    end else if (frame_edge) begin
      show_winner <= winner;
    end
  end

  assign sel_px = show_winner ? win_px : idle_px;

  always_ff @(posedge clk) begin
    if (rst) begin
      px <= '0;
    end else begin
      px.sig <= sel_px.sig;
      if (sel_px.sig.hblnk || sel_px.sig.vblnk) begin
        px.rgb <= BLACK;
      end else begin
        px.rgb <= sel_px.rgb;
      end
    end
  end

  // Both renderers must stay aligned on the same raster position
  assert property (@(posedge clk) disable iff (rst)
    win_px.sig == idle_px.sig)
    else $error("renderer outputs out of step");

endmodule

//--- rtl/game_display_top.sv
// Top level of the game video output
// Timing generator, winner and idle renderers and the screen selector

`timescale 1ns/1ps

module game_display_top #(
  parameter int H_ACTIVE    = 800,
  parameter int H_FP        = 40,
  parameter int H_SYNC      = 128,
  parameter int H_BP        = 88,
  parameter int V_ACTIVE    = 600,
  parameter int V_FP        = 1,
  parameter int V_SYNC      = 4,
  parameter int V_BP        = 23,
  parameter int STRIPE_W    = 32,
  parameter int OUTER_W     = 40,
  parameter int OUTER_H     = 40,
  parameter int INNER_W     = 200,
  parameter int INNER_H     = 150,
  parameter int CHECK_SHIFT = 5
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             winner,
  output vga_pkg::vga_px_t px
);

  import vga_pkg::*;

  vga_sig_t tim;
  vga_px_t  win_px;
  vga_px_t  idle_px;

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
  ) i_vga_timing (
    .clk(clk),
    .rst(rst),
    .tim(tim)
  );

  draw_screen_winner #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .STRIPE_W(STRIPE_W),
    .OUTER_W(OUTER_W), .OUTER_H(OUTER_H), .INNER_W(INNER_W), .INNER_H(INNER_H)
  ) i_draw_screen_winner (
    .clk(clk),
    .rst(rst),
    .tim(tim),
    .px (win_px)
  );

  draw_screen_idle #(
    .CHECK_SHIFT(CHECK_SHIFT)
  ) i_draw_screen_idle (
    .clk(clk),
    .rst(rst),
    .tim(tim),
    .px (idle_px)
  );

  screen_select #(
    .V_ACTIVE(V_ACTIVE)
  ) i_screen_select (
    .clk    (clk),
    .rst    (rst),
    .winner (winner),
    .win_px (win_px),
    .idle_px(idle_px),
    .px     (px)
  );

endmodule

//--- dv/tb_game_display.sv
// Testbench for the game video output
// Random winner toggles, a raster and pixel model, per-pixel checks

`timescale 1ns/1ps

module tb_game_display;

  import vga_pkg::*;

  localparam int H_ACTIVE    = 100;
  localparam int H_FP        = 4;
  localparam int H_SYNC      = 8;
  localparam int H_BP        = 8;
  localparam int V_ACTIVE    = 20;
  localparam int V_FP        = 2;
  localparam int V_SYNC      = 2;
  localparam int V_BP        = 2;
  localparam int STRIPE_W    = 4;
  localparam int OUTER_W     = 10;
  localparam int OUTER_H     = 3;
  localparam int INNER_W     = 30;
  localparam int INNER_H     = 7;
  localparam int CHECK_SHIFT = 2;

  localparam int H_TOTAL    = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL    = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int NUM_FRAMES = 6;
  localparam int MAX_CYCLES = (NUM_FRAMES + 1) * H_TOTAL * V_TOTAL;
  localparam int NUM_TESTS  = 6;

  logic    clk;
  logic    rst;
  logic    winner;
  vga_px_t px;

  int          checks [NUM_TESTS];
  int          errors [NUM_TESTS];
  string       test_name [NUM_TESTS];
  logic [31:0] rnd_state;
  int          mh;
  int          mv;
  logic        model_show;  // Screen choice latched at the last frame boundary
  int          frames_done;
  int          frame_bad;
  int          winner_frames;
  int          idle_frames;
  int          mid_toggles;
  int          cyc;
  int          toggle_at;
  logic        timed_out;
  int          total_checks;
  int          total_errors;

  game_display_top #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
    .STRIPE_W(STRIPE_W), .OUTER_W(OUTER_W), .OUTER_H(OUTER_H),
    .INNER_W(INNER_W), .INNER_H(INNER_H), .CHECK_SHIFT(CHECK_SHIFT)
  ) i_game_display_top (
    .clk   (clk),
    .rst   (rst),
    .winner(winner),
    .px    (px)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic rgb_t stripe_rgb(input int h);
    int   idx;
    rgb_t c;
    idx = h / STRIPE_W;
    if (idx > 24) idx = 24;  // Columns past the last stripe stay red
    case (idx)
      0, 4, 7, 9, 11, 14, 17, 21, 22: c = YELLOW;
      1, 5, 8, 13, 19, 24:            c = RED;
      6, 15, 20:                      c = BLUE;
      3, 12, 18, 23:                  c = GREEN;
      2, 10, 16:                      c = BLACK;
      default:                        c = 12'h888;
    endcase
    return c;
  endfunction

  function automatic logic in_white(input int h, input int v);
    logic outside_outer;
    logic in_inner;
    outside_outer = !((h >= OUTER_W) && (h <= H_ACTIVE - OUTER_W) &&
                      (v >= OUTER_H) && (v < V_ACTIVE - OUTER_H));
    in_inner = (h >= INNER_W) && (h <= H_ACTIVE - INNER_W) &&
               (v >= INNER_H) && (v <= V_ACTIVE - INNER_H);
    return outside_outer || in_inner;
  endfunction

  task automatic expect_eq(input int id, input string what, input longint got,
                           input longint exp);
    checks[id]++;
    assert (got == exp) else begin
      $display("ERROR %0t: %s at (%0d,%0d), got %0h, expected %0h",
               $time, what, mh, mv, got, exp);
      errors[id]++;
    end
  endtask

  task automatic check_pixel();
    vga_sig_t exp_sig;
    rgb_t     exp_rgb;
    logic     blank;
    int       id;
    exp_sig.hcount = coord_t'(mh);
    exp_sig.vcount = coord_t'(mv);
    exp_sig.hblnk  = (mh >= H_ACTIVE);
    exp_sig.vblnk  = (mv >= V_ACTIVE);
    exp_sig.hsync  = (mh >= H_ACTIVE + H_FP) && (mh < H_ACTIVE + H_FP + H_SYNC);
    exp_sig.vsync  = (mv >= V_ACTIVE + V_FP) && (mv < V_ACTIVE + V_FP + V_SYNC);
    expect_eq(1, "raster signals", longint'(px.sig), longint'(exp_sig));
    blank = exp_sig.hblnk || exp_sig.vblnk;
    if (blank) begin
      id = 4;
      exp_rgb = BLACK;
    end else if (model_show) begin
      id = in_white(mh, mv) ? 3 : 2;
      exp_rgb = in_white(mh, mv) ? WHITE : stripe_rgb(mh);
    end else begin
      id = 4;
      exp_rgb = (((mh >> CHECK_SHIFT) & 1) != ((mv >> CHECK_SHIFT) & 1)) ? BLUE : BLACK;
    end
    if (!blank && (px.rgb != exp_rgb)) frame_bad++;
    expect_eq(id, "pixel color", longint'(px.rgb), longint'(exp_rgb));
  endtask

  // Frame bookkeeping, then the raster position of the next pixel
  task automatic step_model();
    if (mh == 0 && mv == 0) begin
      expect_eq(5, "screen at frame start", longint'(px.rgb == WHITE), longint'(model_show));
      if (model_show) winner_frames++;
      else idle_frames++;
    end
    if (mh == 0 && mv == V_ACTIVE) begin
      expect_eq(5, "active pixels off the latched screen", frame_bad, 0);
      frame_bad = 0;
      model_show = winner;  // Value the DUT sampled at this edge
      frames_done++;
    end
    mh++;
    if (mh == H_TOTAL) begin
      mh = 0;
      mv = (mv == V_TOTAL - 1) ? 0 : mv + 1;
    end
  endtask

  initial begin
    test_name[0] = "reset";
    test_name[1] = "raster";
    test_name[2] = "winner stripes";
    test_name[3] = "winner frame";
    test_name[4] = "idle checker and blanking";
    test_name[5] = "frame selection";
    foreach (checks[i]) begin
      checks[i] = 0;
      errors[i] = 0;
    end
    clk = 1'b0;
    rst = 1'b1;
    winner = 1'b0;
    rnd_state = xorshift32(32'heef7d540);
    mh = 0;
    mv = 0;
    model_show = 1'b0;
    frames_done = 0;
    frame_bad = 0;
    winner_frames = 0;
    idle_frames = 0;
    mid_toggles = 0;
    cyc = 0;
    timed_out = 1'b0;
    toggle_at = 1000 + int'(rnd_state % 32'd3000);

    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1;
      expect_eq(0, "output during reset", longint'(px), 0);
    end
    rst = 1'b0;
    @(posedge clk);
    #1;
    expect_eq(0, "output one cycle after reset", longint'(px), 0);

    // Two cycles after release the first pixel of the raster reaches px
    while (frames_done < NUM_FRAMES && !timed_out) begin
      @(posedge clk);
      #1;
      cyc++;
      check_pixel();
      step_model();
      if (cyc == toggle_at) begin
        winner = !winner;
        if (mv < V_ACTIVE) mid_toggles++;
        rnd_state = xorshift32(rnd_state);
        toggle_at = cyc + 1000 + int'(rnd_state % 32'd3000);
      end
      if (cyc >= MAX_CYCLES) timed_out = 1'b1;
    end

    if (timed_out) begin
      $display("Timeout: only %0d of %0d frames finished after %0d cycles",
               frames_done, NUM_FRAMES, cyc);
    end
    if (winner_frames == 0 || idle_frames == 0) begin
      $display("Not both screens were shown: %0d winner frames, %0d idle frames",
               winner_frames, idle_frames);
      errors[5]++;
    end
    total_checks = 0;
    total_errors = 0;
    foreach (checks[i]) begin
      $display("%s: %0d checks, %0d errors", test_name[i], checks[i], errors[i]);
      total_checks += checks[i];
      total_errors += errors[i];
    end
    $display("Totals: %0d checks, %0d errors, %0d frames, %0d mid-frame toggles",
             total_checks, total_errors, frames_done, mid_toggles);
    if (total_errors == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
rtl/vga_pkg.sv
rtl/vga_timing.sv
rtl/draw_screen_winner.sv
rtl/draw_screen_idle.sv
rtl/screen_select.sv
rtl/game_display_top.sv
dv/tb_game_display.sv

//--- Makefile
# Verilator build and run of the game display testbench

VERILATOR ?= verilator
TOP       ?= tb_game_display
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= test failed
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
